// File: include/masku_params.svh
// Mask unit constants
// Lane count, datapath widths, instruction ids and queue depth

`ifndef MASKU_PARAMS_SVH
`define MASKU_PARAMS_SVH

// Lanes sharing one VRF word
`define MASKU_NR_LANES 4

// Lane datapath width in bits
`define MASKU_ELEN 64

// Width of vl, vl up to 1023
`define MASKU_VLEN_W 10

// Instructions in flight at the sequencer, sets the id width
`define MASKU_NR_VINSN 8

// Lane VRF word address, vd on top and beat index below
`define MASKU_ADDR_W 8

// Entries in the result and mask queues
`define MASKU_QUEUE_DEPTH 2

`endif

// File: verilog/masku_types_pkg.sv
// Datapath types of the mask unit
// Lane words, strobes, flat VRF words and the per-lane result entry

`default_nettype none

`include "masku_params.svh"

package masku_types_pkg;

  // One lane data word
  typedef logic [`MASKU_ELEN-1:0] elen_t;

  // Byte strobe of one lane word
  typedef logic [`MASKU_ELEN/8-1:0] strb_t;

  // Flat VRF word over all lanes
  typedef logic [`MASKU_NR_LANES*`MASKU_ELEN-1:0] vword_t;

  typedef logic [$clog2(`MASKU_NR_VINSN)-1:0] vid_t;
  typedef logic [`MASKU_VLEN_W-1:0] vlen_t;

  // Upper bits are vd, lower 3 bits the beat index
  typedef logic [`MASKU_ADDR_W-1:0] vaddr_t;

  // Write request toward one lane VRF
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } masku_result_t;

  typedef masku_result_t [`MASKU_NR_LANES-1:0] lane_results_t;
  typedef strb_t [`MASKU_NR_LANES-1:0] lane_strb_t;

endpackage

`default_nettype wire

// File: verilog/masku_insn_pkg.sv
// Instruction types of the mask unit
// Operation and element width encodings, sequencer request struct

`default_nettype none

package masku_insn_pkg;

  // Mask-logical write or mask distribution
  typedef enum logic {
    OP_MLOGIC   = 1'b0,
    OP_MASKDIST = 1'b1
  } masku_op_e;

  // Element width, 8 << sew bits
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Request from the sequencer
  // vm set means unmasked
  typedef struct packed {
    masku_types_pkg::vid_t  id;
    masku_op_e              op;
    logic                   vm;
    vew_e                   sew;
    masku_types_pkg::vlen_t vl;
    // Destination register, top of the lane word address
    logic [4:0]             vd;
  } masku_req_t;

endpackage

`default_nettype wire

// File: verilog/masku_result_queue.sv
// Result queue toward the lane VRFs
// Two entries per lane, per-lane request/grant, retire once all lanes granted

`timescale 1ns/1ps
`default_nettype none

`include "masku_params.svh"

module masku_result_queue (
  input  wire                            clk_i,
  input  wire                            rst_ni,
  input  wire                            write_i,
  input  masku_types_pkg::lane_results_t entry_i,
  output logic                           full_o,
  output masku_types_pkg::lane_results_t result_o,
  output logic [`MASKU_NR_LANES-1:0]     result_req_o,
  input  wire  [`MASKU_NR_LANES-1:0]     result_gnt_i,
  output logic                           retire_o
);

  localparam int unsigned NrLanes = `MASKU_NR_LANES;
  localparam int unsigned Depth   = `MASKU_QUEUE_DEPTH;
  localparam int unsigned PtrW    = $clog2(Depth);
  localparam int unsigned CntW    = $clog2(Depth + 1);

  masku_types_pkg::lane_results_t queue_q [Depth];
  logic [Depth-1:0][NrLanes-1:0] valid_q;
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] cnt_q;

  // Full holds the operand readies low upstream
  assign full_o = (cnt_q == CntW'(Depth));

  ////////////////////////////////////////
  // Read side
  ////////////////////////////////////////

  assign result_o     = queue_q[rd_ptr_q];
  assign result_req_o = valid_q[rd_ptr_q];

  // Head entry done when no lane is left waiting after this cycle's grants
  assign retire_o = (cnt_q != '0) && ((valid_q[rd_ptr_q] & ~result_gnt_i) == '0);

  ////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (write_i) begin
      queue_q[wr_ptr_q] <= entry_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Granted lanes stop requesting
      valid_q[rd_ptr_q] <= valid_q[rd_ptr_q] & ~result_gnt_i;
      // A new entry requests on all lanes from the next cycle
      if (write_i) begin
        valid_q[wr_ptr_q] <= '1;
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (retire_o) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CntW'(write_i) - CntW'(retire_o);
    end
  end

  // Merge stage must see full and hold off
  a_no_write_full : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    write_i |-> !full_o
  );

endmodule

`default_nettype wire

// File: verilog/masku_mask_dist.sv
// Mask distributor
// Mask bit to byte strobe expansion per element width
// Per-lane two-entry strobe queue with handshake and retire

`timescale 1ns/1ps
`default_nettype none

`include "masku_params.svh"

module masku_mask_dist (
  input  wire                         clk_i,
  input  wire                         rst_ni,
  input  masku_insn_pkg::masku_req_t  insn_i,
  input  wire                         active_i,
  input  masku_types_pkg::vlen_t      issue_idx_i,
  input  wire                         issue_last_i,
  input  masku_types_pkg::vword_t     mask_i,
  input  wire                         mask_valid_i,
  output logic                        mask_ready_o,
  output logic                        issue_step_o,
  output logic                        commit_step_o,
  output masku_types_pkg::lane_strb_t mask_o,
  output logic [`MASKU_NR_LANES-1:0]  mask_valid_o,
  input  wire  [`MASKU_NR_LANES-1:0]  mask_ready_i
);

  localparam int unsigned NrLanes = `MASKU_NR_LANES;
  localparam int unsigned NrBytes = NrLanes * `MASKU_ELEN / 8;
  localparam int unsigned Depth   = `MASKU_QUEUE_DEPTH;
  localparam int unsigned PtrW    = $clog2(Depth);
  localparam int unsigned CntW    = $clog2(Depth + 1);
  localparam int unsigned IdxW    = `MASKU_VLEN_W + 1;

  masku_types_pkg::lane_strb_t ring_q [Depth];
  logic [Depth-1:0][NrLanes-1:0] valid_q;
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic [IdxW-1:0] word_base;
  logic [IdxW-1:0] next_base;
  logic [7:0]      bit_base;
  logic [NrBytes-1:0] elem_on;
  logic [NrBytes-1:0] strb_flat;
  logic ring_full;
  logic ring_write;

  ////////////////////////////////////////
  // Strobe expansion
  ////////////////////////////////////////

  // First element of this word is w * (32 >> sew)
  assign word_base = {1'b0, issue_idx_i} << (3'd5 - {1'b0, insn_i.sew});
  assign next_base = word_base + (IdxW'(NrBytes) >> insn_i.sew);
  // Position inside the current 256-bit mask beat
  assign bit_base  = word_base[7:0];

  always_comb begin
    // Element on when inside vl and its mask bit is set
    for (int e = 0; e < NrBytes; e++) begin
      elem_on[e] = ((word_base + IdxW'(e)) < {1'b0, insn_i.vl}) &&
                   mask_i[bit_base + 8'(e)];
    end
    // Each element spans 1 << sew flat bytes
    for (int b = 0; b < NrBytes; b++) begin
      strb_flat[b] = elem_on[b >> insn_i.sew];
    end
  end

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  assign ring_full    = (cnt_q == CntW'(Depth));
  assign ring_write   = active_i && (insn_i.op == masku_insn_pkg::OP_MASKDIST) &&
                        mask_valid_i && !ring_full;
  assign issue_step_o = ring_write;

  // Release the mask beat once its bits are used up or the last word went out
  assign mask_ready_o = ring_write && ((next_base[7:0] == 8'd0) || issue_last_i);

  // Head entry leaves once every lane has taken or is taking its byte
  assign commit_step_o = (cnt_q != '0) && ((valid_q[rd_ptr_q] & ~mask_ready_i) == '0);

  assign mask_o       = ring_q[rd_ptr_q];
  assign mask_valid_o = valid_q[rd_ptr_q];

  ////////////////////////////////////////
  // Strobe ring
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (ring_write) begin
      ring_q[wr_ptr_q] <= masku_types_pkg::lane_strb_t'(strb_flat);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Lanes drop out one by one as they accept
      valid_q[rd_ptr_q] <= valid_q[rd_ptr_q] & ~mask_ready_i;
      if (ring_write) begin
        valid_q[wr_ptr_q] <= '1;
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (commit_step_o) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CntW'(ring_write) - CntW'(commit_step_o);
    end
  end

  // A written entry is offered to the lanes from the next cycle on
  a_write_offered : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ring_write |=> (mask_valid_o != '0)
  );

endmodule

`default_nettype wire

// File: verilog/masku_mlogic_stage.sv
// Mask-logical merge stage
// Bit enable from vl and mask, a/b merge, lane entries and operand handshakes

`timescale 1ns/1ps
`default_nettype none

`include "masku_params.svh"

module masku_mlogic_stage (
  input  masku_insn_pkg::masku_req_t     insn_i,
  input  wire                            active_i,
  input  masku_types_pkg::vlen_t         issue_idx_i,
  input  wire                            queue_full_i,
  input  masku_types_pkg::vword_t        opa_i,
  input  wire                            opa_valid_i,
  output logic                           opa_ready_o,
  input  masku_types_pkg::vword_t        opb_i,
  input  wire                            opb_valid_i,
  output logic                           opb_ready_o,
  input  masku_types_pkg::vword_t        mask_i,
  input  wire                            mask_valid_i,
  output logic                           mask_ready_o,
  output logic                           write_o,
  output masku_types_pkg::lane_results_t entry_o
);

  localparam int unsigned NrLanes = `MASKU_NR_LANES;
  localparam int unsigned Elen    = `MASKU_ELEN;

  masku_types_pkg::vlen_t  beat_base;
  masku_types_pkg::vlen_t  remain;
  masku_types_pkg::vword_t vl_en;
  masku_types_pkg::vword_t bit_en;
  masku_types_pkg::vword_t merged;
  logic mask_ok;

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  // Mask beat only needed for a masked instruction
  assign mask_ok = insn_i.vm || mask_valid_i;
  assign write_o = active_i && (insn_i.op == masku_insn_pkg::OP_MLOGIC) &&
                   !queue_full_i && opa_valid_i && opb_valid_i && mask_ok;

  assign opa_ready_o  = write_o;
  assign opb_ready_o  = write_o;
  assign mask_ready_o = write_o && !insn_i.vm;

  ////////////////////////////////////////
  // Bit enable and merge
  ////////////////////////////////////////

  // Bits of vl left from this beat on
  assign beat_base = masku_types_pkg::vlen_t'(issue_idx_i << 8);
  assign remain    = insn_i.vl - beat_base;

  // Tail beat keeps only the low remain bits
  assign vl_en  = (remain >= masku_types_pkg::vlen_t'(NrLanes * Elen)) ? '1 :
                  ~(masku_types_pkg::vword_t'('1) << remain);
  assign bit_en = insn_i.vm ? vl_en : (vl_en & mask_i);
  assign merged = (opa_i & bit_en) | (opb_i & ~bit_en);

  // Same id and address on every lane, full byte enables
  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      entry_o[l].id    = insn_i.id;
      entry_o[l].addr  = {insn_i.vd, issue_idx_i[2:0]};
      entry_o[l].wdata = merged[l*Elen +: Elen];
      entry_o[l].be    = '1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/masku_insn_ctrl.sv
// Mask unit instruction control
// Single busy register, beat total, issue and retire counters, done strobe

`timescale 1ns/1ps
`default_nettype none

`include "masku_params.svh"

module masku_insn_ctrl (
  input  wire                        clk_i,
  input  wire                        rst_ni,
  input  masku_insn_pkg::masku_req_t req_i,
  input  wire                        req_valid_i,
  output logic                       req_ready_o,
  output masku_insn_pkg::masku_req_t insn_o,
  output logic                       active_o,
  input  wire                        issue_step_i,
  input  wire                        commit_step_i,
  output masku_types_pkg::vlen_t     issue_idx_o,
  output logic                       issue_last_o,
  output logic                       done_o,
  output masku_types_pkg::vid_t      done_id_o
);

  // One extra bit for the rounding sums
  localparam int unsigned CntW = `MASKU_VLEN_W + 1;

  masku_insn_pkg::masku_req_t insn_q;
  masku_types_pkg::vlen_t     total_q;
  masku_types_pkg::vlen_t     total_d;
  masku_types_pkg::vlen_t     issued_q;
  masku_types_pkg::vlen_t     retired_q;
  logic [CntW-1:0] vl_ext;
  logic [CntW-1:0] epw_m1;
  logic [2:0]      epw_shift;
  logic busy_q;
  logic accept;

  assign accept      = req_valid_i && req_ready_o;
  assign req_ready_o = !busy_q;

  ////////////////////////////////////////
  // Beat total
  ////////////////////////////////////////

  // Mask-logical takes one beat per 256 bits of vl
  // Distribution takes one word per 32 >> sew elements
  assign vl_ext    = {1'b0, req_i.vl};
  assign epw_shift = 3'd5 - {1'b0, req_i.sew};
  assign epw_m1    = (CntW'(32) >> req_i.sew) - CntW'(1);

  always_comb begin
    if (req_i.op == masku_insn_pkg::OP_MLOGIC) begin
      total_d = masku_types_pkg::vlen_t'((vl_ext + CntW'(255)) >> 8);
    end else begin
      total_d = masku_types_pkg::vlen_t'((vl_ext + epw_m1) >> epw_shift);
    end
  end

  // Request and its beat total, latched on acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q  <= req_i;
      total_q <= total_d;
    end
  end

  ////////////////////////////////////////
  // Counters
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      issued_q  <= '0;
      retired_q <= '0;
    end else if (accept) begin
      busy_q    <= 1'b1;
      issued_q  <= '0;
      retired_q <= '0;
    end else begin
      if (issue_step_i) begin
        issued_q <= issued_q + 1'b1;
      end
      if (commit_step_i) begin
        retired_q <= retired_q + 1'b1;
      end
      // Busy drops the cycle after done
      if (done_o) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign insn_o       = insn_q;
  // Issue phase open while beats remain
  assign active_o     = busy_q && (issued_q != total_q);
  assign issue_idx_o  = issued_q;
  assign issue_last_o = (issued_q == total_q - 1'b1);

  // All beats retired by the cycle after the last retire
  assign done_o    = busy_q && (retired_q == total_q);
  assign done_id_o = insn_q.id;

  // A waiting request stays valid and unchanged until it is taken
  a_req_hold : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (req_valid_i && !req_ready_o) |=> (req_valid_i && $stable(req_i))
  );

endmodule

`default_nettype wire

// File: verilog/masku_top.sv
// Mask unit top level
// Instruction control, mask-logical merge, mask distribution and result queue

`timescale 1ns/1ps
`default_nettype none

`include "masku_params.svh"

module masku_top (
  input  wire                            clk_i,
  input  wire                            rst_ni,
  // Sequencer
  input  masku_insn_pkg::masku_req_t     req_i,
  input  wire                            req_valid_i,
  output logic                           req_ready_o,
  output logic                           done_o,
  output masku_types_pkg::vid_t          done_id_o,
  // Operands from the lanes
  input  masku_types_pkg::vword_t        opa_i,
  input  wire                            opa_valid_i,
  output logic                           opa_ready_o,
  input  masku_types_pkg::vword_t        opb_i,
  input  wire                            opb_valid_i,
  output logic                           opb_ready_o,
  input  masku_types_pkg::vword_t        mask_i,
  input  wire                            mask_valid_i,
  output logic                           mask_ready_o,
  // Results toward the VRF
  output masku_types_pkg::lane_results_t result_o,
  output logic [`MASKU_NR_LANES-1:0]     result_req_o,
  input  wire  [`MASKU_NR_LANES-1:0]     result_gnt_i,
  // Strobes toward the lanes
  output masku_types_pkg::lane_strb_t    mask_o,
  output logic [`MASKU_NR_LANES-1:0]     mask_valid_o,
  input  wire  [`MASKU_NR_LANES-1:0]     mask_ready_i
);

  masku_insn_pkg::masku_req_t     insn;
  masku_types_pkg::vlen_t         issue_idx;
  masku_types_pkg::lane_results_t ml_entry;
  logic active;
  logic issue_last;
  logic issue_step;
  logic commit_step;
  logic ml_write;
  logic ml_mask_ready;
  logic md_mask_ready;
  logic md_issue_step;
  logic md_commit_step;
  logic rq_full;
  logic rq_retire;

  ////////////////////////////////////////
  // Beat sources
  ////////////////////////////////////////

  // Only one source runs per instruction, so plain ORs merge them
  assign issue_step   = ml_write | md_issue_step;
  assign commit_step  = rq_retire | md_commit_step;
  assign mask_ready_o = ml_mask_ready | md_mask_ready;

  masku_insn_ctrl u_insn_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .insn_o        (insn),
    .active_o      (active),
    .issue_step_i  (issue_step),
    .commit_step_i (commit_step),
    .issue_idx_o   (issue_idx),
    .issue_last_o  (issue_last),
    .done_o        (done_o),
    .done_id_o     (done_id_o)
  );

  masku_mlogic_stage u_mlogic_stage (
    .insn_i       (insn),
    .active_i     (active),
    .issue_idx_i  (issue_idx),
    .queue_full_i (rq_full),
    .opa_i        (opa_i),
    .opa_valid_i  (opa_valid_i),
    .opa_ready_o  (opa_ready_o),
    .opb_i        (opb_i),
    .opb_valid_i  (opb_valid_i),
    .opb_ready_o  (opb_ready_o),
    .mask_i       (mask_i),
    .mask_valid_i (mask_valid_i),
    .mask_ready_o (ml_mask_ready),
    .write_o      (ml_write),
    .entry_o      (ml_entry)
  );

  masku_mask_dist u_mask_dist (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .insn_i        (insn),
    .active_i      (active),
    .issue_idx_i   (issue_idx),
    .issue_last_i  (issue_last),
    .mask_i        (mask_i),
    .mask_valid_i  (mask_valid_i),
    .mask_ready_o  (md_mask_ready),
    .issue_step_o  (md_issue_step),
    .commit_step_o (md_commit_step),
    .mask_o        (mask_o),
    .mask_valid_o  (mask_valid_o),
    .mask_ready_i  (mask_ready_i)
  );

  masku_result_queue u_result_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .write_i      (ml_write),
    .entry_i      (ml_entry),
    .full_o       (rq_full),
    .result_o     (result_o),
    .result_req_o (result_req_o),
    .result_gnt_i (result_gnt_i),
    .retire_o     (rq_retire)
  );

endmodule

`default_nettype wire

// File: test/tb_masku.sv
// Testbench for the mask unit
// LFSR driven instructions, operands and back-pressure
// Reference model with per-lane expected queues, compare tasks, timeout

`timescale 1ns/1ps
`default_nettype none

`include "masku_params.svh"

module tb_masku;

  localparam int NrLanes   = `MASKU_NR_LANES;
  localparam int NrInsn    = 40;
  localparam int InsnLimit = 200;
  localparam int MaxCycles = NrInsn * InsnLimit;

  logic clk_i;
  logic rst_ni;
  masku_insn_pkg::masku_req_t     req_i;
  logic                           req_valid_i;
  logic                           req_ready_o;
  logic                           done_o;
  masku_types_pkg::vid_t          done_id_o;
  masku_types_pkg::vword_t        opa_i;
  logic                           opa_valid_i;
  logic                           opa_ready_o;
  masku_types_pkg::vword_t        opb_i;
  logic                           opb_valid_i;
  logic                           opb_ready_o;
  masku_types_pkg::vword_t        mask_i;
  logic                           mask_valid_i;
  logic                           mask_ready_o;
  masku_types_pkg::lane_results_t result_o;
  logic [NrLanes-1:0]             result_req_o;
  logic [NrLanes-1:0]             result_gnt_i;
  masku_types_pkg::lane_strb_t    mask_o;
  logic [NrLanes-1:0]             mask_valid_o;
  logic [NrLanes-1:0]             mask_ready_i;

  // Operand beats waiting to be offered on each channel
  masku_types_pkg::vword_t opa_q[$];
  masku_types_pkg::vword_t opb_q[$];
  masku_types_pkg::vword_t mask_q[$];
  // Expected model output per lane in order
  masku_types_pkg::masku_result_t exp_res[NrLanes][$];
  masku_types_pkg::strb_t         exp_strb[NrLanes][$];
  masku_types_pkg::vid_t          exp_done[$];
  // Next instruction staged until its acceptance
  masku_insn_pkg::masku_req_t     stg_req;
  masku_types_pkg::vword_t        stg_opa[$];
  masku_types_pkg::vword_t        stg_opb[$];
  masku_types_pkg::vword_t        stg_mask[$];
  masku_types_pkg::masku_result_t stg_res[NrLanes][$];
  masku_types_pkg::strb_t         stg_strb[NrLanes][$];

  logic [31:0] lfsr_q = 32'hc253bed5;
  logic insn_busy = 1'b0;
  int n_prepared = 0;
  int n_accepted = 0;
  int n_done = 0;
  int cycle_cnt = 0;

  masku_top DUT (.*);

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Random source
  ////////////////////////////////////////

  // Galois LFSR stepped once per returned bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic masku_types_pkg::vword_t rand_vword();
    masku_types_pkg::vword_t v;
    for (int i = 0; i < 8; i++) begin
      v[i*32 +: 32] = rand_bits(32);
    end
    return v;
  endfunction

  // True about 5 times in 16
  function automatic logic withhold();
    return rand_bits(4) < 5;
  endfunction

  ////////////////////////////////////////
  // Failure and compare tasks
  ////////////////////////////////////////

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation aborted");
  endtask

  task automatic fail_value(input string msg);
    abort_run($sformatf("[FAIL] %0t ns: %s", $time, msg));
  endtask

  task automatic check_result(input int lane, input masku_types_pkg::masku_result_t got);
    masku_types_pkg::masku_result_t want;
    if (exp_res[lane].size() == 0) begin
      abort_run($sformatf("Lane %0d was granted a result that no instruction produces", lane));
    end else begin
      want = exp_res[lane].pop_front();
      if (got !== want) begin
        fail_value($sformatf("lane %0d result id %0d addr %h be %h wdata %h, %s %0d %h %h %h",
                             lane, got.id, got.addr, got.be, got.wdata, "expected",
                             want.id, want.addr, want.be, want.wdata));
      end
    end
  endtask

  task automatic check_strb(input int lane, input masku_types_pkg::strb_t got);
    masku_types_pkg::strb_t want;
    if (exp_strb[lane].size() == 0) begin
      abort_run($sformatf("Lane %0d took a strobe byte that no instruction produces", lane));
    end else begin
      want = exp_strb[lane].pop_front();
      if (got !== want) begin
        fail_value($sformatf("lane %0d strobe %b, expected %b", lane, got, want));
      end
    end
  endtask

  task automatic check_done(input masku_types_pkg::vid_t got);
    masku_types_pkg::vid_t want;
    if (!insn_busy || exp_done.size() == 0) begin
      abort_run("done_o pulsed while no instruction was running");
    end else begin
      want = exp_done.pop_front();
      if (got !== want) begin
        fail_value($sformatf("done id %0d, expected %0d", got, want));
      end
      // Every entry of the instruction must be gone before done
      for (int l = 0; l < NrLanes; l++) begin
        if (exp_res[l].size() != 0 || exp_strb[l].size() != 0) begin
          abort_run($sformatf("done_o pulsed before lane %0d took all its entries", l));
        end
      end
    end
  endtask

  task automatic check_idle();
    if (!req_ready_o || done_o || result_req_o != '0 || mask_valid_o != '0 ||
        opa_ready_o || opb_ready_o || mask_ready_o) begin
      fail_value($sformatf("after reset req_ready %b done %b req %b mvalid %b rdy %b%b%b",
                           req_ready_o, done_o, result_req_o, mask_valid_o,
                           opa_ready_o, opb_ready_o, mask_ready_o));
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Bit i of beat k takes a inside vl where the mask allows, else b
  task automatic expect_mlogic(input masku_insn_pkg::masku_req_t r, input int k,
                               input masku_types_pkg::vword_t a,
                               input masku_types_pkg::vword_t b,
                               input masku_types_pkg::vword_t m);
    masku_types_pkg::vword_t merged;
    masku_types_pkg::masku_result_t e;
    for (int i = 0; i < 256; i++) begin
      merged[i] = ((k * 256 + i) < int'(r.vl) && (r.vm || m[i])) ? a[i] : b[i];
    end
    for (int l = 0; l < NrLanes; l++) begin
      e.id    = r.id;
      e.addr  = {r.vd, 3'(k)};
      e.wdata = merged[l*64 +: 64];
      e.be    = '1;
      stg_res[l].push_back(e);
    end
  endtask

  // Flat byte b of word w belongs to element b / (1 << sew)
  task automatic expect_maskdist(input masku_insn_pkg::masku_req_t r, input int w,
                                 input masku_types_pkg::vword_t m);
    logic [31:0] flat;
    int epw;
    int g;
    epw = 32 >> int'(r.sew);
    for (int b = 0; b < 32; b++) begin
      g = w * epw + b / (1 << int'(r.sew));
      flat[b] = (g < int'(r.vl)) && m[g % 256];
    end
    for (int l = 0; l < NrLanes; l++) begin
      stg_strb[l].push_back(flat[l*8 +: 8]);
    end
  endtask

  task automatic prepare_insn();
    masku_insn_pkg::masku_req_t r;
    masku_types_pkg::vword_t a;
    masku_types_pkg::vword_t b;
    masku_types_pkg::vword_t m;
    int epw;
    int nwords;
    r.id  = masku_types_pkg::vid_t'(rand_bits(3));
    r.op  = masku_insn_pkg::masku_op_e'(1'(rand_bits(1)));
    r.vm  = rand_bits(1) != 0;
    r.sew = masku_insn_pkg::vew_e'(2'(rand_bits(2)));
    r.vl  = masku_types_pkg::vlen_t'(rand_bits(10));
    r.vd  = 5'(rand_bits(5));
    if (r.vl == '0) begin
      r.vl = masku_types_pkg::vlen_t'(1);
    end
    stg_opa.delete();
    stg_opb.delete();
    stg_mask.delete();
    if (r.op == masku_insn_pkg::OP_MLOGIC) begin
      for (int k = 0; k < (int'(r.vl) + 255) / 256; k++) begin
        a = rand_vword();
        b = rand_vword();
        m = '1;
        stg_opa.push_back(a);
        stg_opb.push_back(b);
        // Unmasked beats read no mask
        if (!r.vm) begin
          m = rand_vword();
          stg_mask.push_back(m);
        end
        expect_mlogic(r, k, a, b, m);
      end
    end else begin
      epw    = 32 >> int'(r.sew);
      nwords = (int'(r.vl) + epw - 1) / epw;
      for (int k = 0; k < (nwords * epw + 255) / 256; k++) begin
        stg_mask.push_back(rand_vword());
      end
      for (int w = 0; w < nwords; w++) begin
        expect_maskdist(r, w, stg_mask[w * epw / 256]);
      end
    end
    stg_req = r;
  endtask

  ////////////////////////////////////////
  // Stimulus called once per cycle
  ////////////////////////////////////////

  task automatic drive_cycle();
    if (req_valid_i && n_accepted == n_prepared) begin
      req_valid_i = 1'b0;
    end
    // The next request may wait while the current one runs
    if (!req_valid_i && n_prepared < NrInsn && n_accepted == n_prepared && !withhold()) begin
      prepare_insn();
      req_i       = stg_req;
      req_valid_i = 1'b1;
      n_prepared++;
    end
    opa_valid_i  = (opa_q.size() != 0) && !withhold();
    opa_i        = (opa_q.size() != 0) ? opa_q[0] : '0;
    opb_valid_i  = (opb_q.size() != 0) && !withhold();
    opb_i        = (opb_q.size() != 0) ? opb_q[0] : '0;
    mask_valid_i = (mask_q.size() != 0) && !withhold();
    mask_i       = (mask_q.size() != 0) ? mask_q[0] : '0;
    for (int l = 0; l < NrLanes; l++) begin
      result_gnt_i[l] = !withhold();
      mask_ready_i[l] = !withhold();
    end
  endtask

  ////////////////////////////////////////
  // Monitor sampling handshakes mid-cycle
  ////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (opa_valid_i && opa_ready_o) begin
        void'(opa_q.pop_front());
      end
      if (opb_valid_i && opb_ready_o) begin
        void'(opb_q.pop_front());
      end
      if (mask_valid_i && mask_ready_o) begin
        void'(mask_q.pop_front());
      end
      for (int l = 0; l < NrLanes; l++) begin
        if (result_req_o[l] && result_gnt_i[l]) begin
          check_result(l, result_o[l]);
        end
        if (mask_valid_o[l] && mask_ready_i[l]) begin
          check_strb(l, mask_o[l]);
        end
      end
      // Ready is low exactly from acceptance through the done cycle
      if (req_ready_o == insn_busy) begin
        fail_value($sformatf("req_ready_o %b with busy %b", req_ready_o, insn_busy));
      end
      if (done_o) begin
        check_done(done_id_o);
        insn_busy = 1'b0;
        n_done++;
      end
      if (req_valid_i && req_ready_o) begin
        insn_busy = 1'b1;
        n_accepted++;
        exp_done.push_back(stg_req.id);
        foreach (stg_opa[i]) begin
          opa_q.push_back(stg_opa[i]);
        end
        foreach (stg_opb[i]) begin
          opb_q.push_back(stg_opb[i]);
        end
        foreach (stg_mask[i]) begin
          mask_q.push_back(stg_mask[i]);
        end
        for (int l = 0; l < NrLanes; l++) begin
          for (int i = 0; i < stg_res[l].size(); i++) begin
            exp_res[l].push_back(stg_res[l][i]);
          end
          for (int i = 0; i < stg_strb[l].size(); i++) begin
            exp_strb[l].push_back(stg_strb[l][i]);
          end
          stg_res[l].delete();
          stg_strb[l].delete();
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= MaxCycles) begin
      abort_run($sformatf("Timeout: the run was still going after %0d cycles", MaxCycles));
    end
  end

  initial begin
    rst_ni       = 1'b0;
    req_i        = '0;
    req_valid_i  = 1'b0;
    opa_i        = '0;
    opa_valid_i  = 1'b0;
    opb_i        = '0;
    opb_valid_i  = 1'b0;
    mask_i       = '0;
    mask_valid_i = 1'b0;
    result_gnt_i = '0;
    mask_ready_i = '0;
    repeat (5) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    @(negedge clk_i);
    check_idle();
    while (n_done < NrInsn) begin
      @(posedge clk_i);
      #1;
      drive_cycle();
    end
    if (opa_q.size() == 0 && opb_q.size() == 0 && mask_q.size() == 0 &&
        exp_done.size() == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      abort_run("Operand beats or done ids were left over at the end of the run");
    end
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
verilog/masku_types_pkg.sv
verilog/masku_insn_pkg.sv
verilog/masku_result_queue.sv
verilog/masku_mask_dist.sv
verilog/masku_mlogic_stage.sv
verilog/masku_insn_ctrl.sv
verilog/masku_top.sv
test/tb_masku.sv

// File: Makefile
# Verilator build and run of the mask unit testbench

SIM  := obj_dir/Vtb_masku
SRCS := $(filter-out +%,$(shell cat sources.f)) include/masku_params.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): sources.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_masku -f sources.f

# Pass only when the pass line shows up in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf obj_dir
